/* m92_mem_pkg.sv */
// Constants and bus types for the channel 3 port; single clock domain, byte addresses, 16-bit words
package m92_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Channel widths
    ////////////////////////////////////////////////////////////

    // Byte address into the shared memory
    localparam int MEM_ADDR_W = 25;
    localparam int MEM_DATA_W = 16;
    localparam int MEM_BE_W   = 2;

    // High-score engine addresses the CPU bus directly
    localparam int HS_ADDR_W  = 20;

    ////////////////////////////////////////////////////////////
    // Region map and download indices
    ////////////////////////////////////////////////////////////

    localparam logic [MEM_ADDR_W-1:0] REGION_ROM_BASE     = 25'h000_0000;
    // 64 KiB aligned, only bits 24..16 matter
    localparam logic [MEM_ADDR_W-1:0] REGION_CPU_RAM_BASE = 25'h100_0000;

    localparam logic [7:0] IDX_ROM = 8'd0;
    localparam logic [7:0] IDX_DIP = 8'd254;

    // DIP switch bank
    localparam int DIP_BANKS = 8;
    localparam int DIP_USED  = 3;
    localparam int DIP_SEL_W = $clog2(DIP_BANKS);

    ////////////////////////////////////////////////////////////
    // Bus structs
    ////////////////////////////////////////////////////////////

    // Host download stream, one byte per wr strobe
    typedef struct packed {
        logic                  download;
        logic [7:0]            index;
        logic                  wr;
        logic [MEM_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } dl_stream_t;

    // High-score side, enables are levels
    typedef struct packed {
        logic [HS_ADDR_W-1:0] address;
        logic [7:0]           data_in;
        logic                 read_en;
        logic                 write_en;
    } hs_cmd_t;

    // One memory transaction, rnw high for a read
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic [MEM_DATA_W-1:0] din;
        logic [MEM_BE_W-1:0]   be;
        logic                  rnw;
    } mem_cmd_t;

    // Channel owner of the arbiter
    typedef enum logic [1:0] {
        OWN_IDLE,
        OWN_DL,
        OWN_HS
    } ch3_owner_e;

endpackage

/* rom_download_writer.sv */
// ROM bytes on index 0 packed into word writes; host must not strobe wr while dl_wait is high
`timescale 1ns/100ps

module rom_download_writer (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  m92_mem_pkg::dl_stream_t              dl,
    output logic                                 req,
    output m92_mem_pkg::mem_cmd_t                cmd,
    input  logic                                 rdy,
    output logic                                 dl_wait,
    output logic [m92_mem_pkg::DIP_USED*8-1:0]   dip_sw
);
    import m92_mem_pkg::*;

    logic                  rom_wr;
    logic                  dip_wr;
    logic                  flush;
    logic                  hold_match;
    logic                  hold_valid;
    logic [7:0]            hold_byte;
    logic [MEM_ADDR_W-1:0] hold_addr;
    logic [7:0]            dip_bank [DIP_BANKS];

    ////////////////////////////////////////////////////////////
    // Index decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        rom_wr = dl.download && dl.wr && (dl.index == IDX_ROM);
        dip_wr = dl.wr && (dl.index == IDX_DIP) && (dl.addr < DIP_BANKS);
        // Low byte waiting for its partner in the same word
        hold_match = hold_valid &&
                     (hold_addr[MEM_ADDR_W-1:1] == dl.addr[MEM_ADDR_W-1:1]);
        // Trailing even byte once the stream has ended and the channel is free
        flush = hold_valid && !dl.download && !dl_wait;
    end

    ////////////////////////////////////////////////////////////
    // Byte pairing and request control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
            req        <= 1'b0;
            dl_wait    <= 1'b0;
        end else begin
            req <= 1'b0;
            if (rdy) begin
                dl_wait <= 1'b0;
            end
            if (rom_wr && !dl.addr[0]) begin
                hold_valid <= 1'b1;
            end else if (rom_wr || flush) begin
                // Odd byte completes the word, or the flush goes out alone
                req        <= 1'b1;
                dl_wait    <= 1'b1;
                hold_valid <= 1'b0;
            end
        end
    end

    // Held byte and outgoing command
    always_ff @(posedge clk_sys) begin
        if (rom_wr && !dl.addr[0]) begin
            hold_byte <= dl.data;
            hold_addr <= dl.addr;
        end
        if (rom_wr && dl.addr[0]) begin
            cmd.addr <= REGION_ROM_BASE + {dl.addr[MEM_ADDR_W-1:1], 1'b0};
            cmd.din  <= {dl.data, hold_byte};
            // Low lane only if its byte really arrived
            cmd.be   <= {1'b1, hold_match};
            cmd.rnw  <= 1'b0;
        end else if (flush) begin
            cmd.addr <= REGION_ROM_BASE + {hold_addr[MEM_ADDR_W-1:1], 1'b0};
            cmd.din  <= {8'h00, hold_byte};
            cmd.be   <= 2'b01;
            cmd.rnw  <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // DIP switch bank
    ////////////////////////////////////////////////////////////

    // Switches are active low so an empty bank reads all ones
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            for (int i = 0; i < DIP_BANKS; i++) begin
                dip_bank[i] <= 8'hFF;
            end
        end else if (dip_wr) begin
            dip_bank[dl.addr[DIP_SEL_W-1:0]] <= dl.data;
        end
    end

    // Byte 0 in the lowest lane
    always_comb begin
        for (int i = 0; i < DIP_USED; i++) begin
            dip_sw[i*8 +: 8] = dip_bank[i];
        end
    end

endmodule

/* hiscore_ram_bridge.sv */
// Byte access to CPU work RAM from the high-score engine; one request in flight, edges while busy are lost
`timescale 1ns/100ps

module hiscore_ram_bridge (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  m92_mem_pkg::hs_cmd_t                 hs,
    output logic                                 req,
    output m92_mem_pkg::mem_cmd_t                cmd,
    input  logic                                 rdy,
    input  logic [m92_mem_pkg::MEM_DATA_W-1:0]   dout,
    output logic [7:0]                           hs_data_out,
    output logic                                 hs_data_ready
);
    import m92_mem_pkg::*;

    logic read_q;
    logic write_q;
    logic read_rise;
    logic write_rise;
    logic busy;
    logic is_write;
    logic byte_hi;

    ////////////////////////////////////////////////////////////
    // Enable edge detect
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            read_q  <= hs.read_en;
            write_q <= hs.write_en;
        end
    end

    always_comb begin
        read_rise  = hs.read_en && !read_q;
        write_rise = hs.write_en && !write_q;
    end

    ////////////////////////////////////////////////////////////
    // Request and completion
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            req           <= 1'b0;
            busy          <= 1'b0;
            hs_data_ready <= 1'b0;
        end else begin
            req           <= 1'b0;
            hs_data_ready <= 1'b0;
            if (!busy) begin
                if (read_rise || write_rise) begin
                    req  <= 1'b1;
                    busy <= 1'b1;
                end
            end else if (rdy) begin
                busy          <= 1'b0;
                hs_data_ready <= 1'b1;
            end
        end
    end

    // Word address in the CPU RAM region, lane picked by address bit 0
    always_ff @(posedge clk_sys) begin
        if (!busy && (read_rise || write_rise)) begin
            is_write <= write_rise;
            byte_hi  <= hs.address[0];
            cmd.addr <= {REGION_CPU_RAM_BASE[MEM_ADDR_W-1:16], hs.address[15:1], 1'b0};
            cmd.din  <= {hs.data_in, hs.data_in};
            cmd.be   <= write_rise ? {hs.address[0], !hs.address[0]} : 2'b00;
            cmd.rnw  <= !write_rise;
        end
    end

    // Read data is only captured for reads
    always_ff @(posedge clk_sys) begin
        if (busy && rdy && !is_write) begin
            hs_data_out <= byte_hi ? dout[15:8] : dout[7:0];
        end
    end

endmodule

/* ch3_arbiter.sv */
// Two-source arbiter for memory channel 3; download has priority, owner held until mem_rdy
`timescale 1ns/100ps

module ch3_arbiter (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  logic                    dl_req,
    input  m92_mem_pkg::mem_cmd_t   dl_cmd,
    output logic                    dl_rdy,
    input  logic                    hs_req,
    input  m92_mem_pkg::mem_cmd_t   hs_cmd,
    output logic                    hs_rdy,
    output logic                    mem_req,
    output m92_mem_pkg::mem_cmd_t   mem_cmd,
    input  logic                    mem_rdy
);
    import m92_mem_pkg::*;

    ch3_owner_e owner;
    logic       dl_pend;
    logic       hs_pend;
    mem_cmd_t   dl_cmd_q;
    mem_cmd_t   hs_cmd_q;
    logic       dl_want;
    logic       hs_want;
    logic       chan_free;
    logic       grant_dl;
    logic       grant_hs;

    ////////////////////////////////////////////////////////////
    // Grant decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        // A fresh req counts in its own cycle so an idle grant costs one clock
        dl_want   = dl_req || dl_pend;
        hs_want   = hs_req || hs_pend;
        // Channel frees on the ready of the transaction in flight
        chan_free = (owner == OWN_IDLE) || mem_rdy;
        grant_dl  = chan_free && dl_want;
        grant_hs  = chan_free && !dl_want && hs_want;
    end

    ////////////////////////////////////////////////////////////
    // Owner state and pending flags
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            owner   <= OWN_IDLE;
            mem_req <= 1'b0;
            dl_pend <= 1'b0;
            hs_pend <= 1'b0;
        end else begin
            mem_req <= grant_dl || grant_hs;
            dl_pend <= (dl_pend || dl_req) && !grant_dl;
            hs_pend <= (hs_pend || hs_req) && !grant_hs;
            if (grant_dl) begin
                owner <= OWN_DL;
            end else if (grant_hs) begin
                owner <= OWN_HS;
            end else if (mem_rdy) begin
                owner <= OWN_IDLE;
            end
        end
    end

    // Commands of the waiting sources
    always_ff @(posedge clk_sys) begin
        if (dl_req) begin
            dl_cmd_q <= dl_cmd;
        end
        if (hs_req) begin
            hs_cmd_q <= hs_cmd;
        end
    end

    // Command to the channel, taken straight from the port on a same-cycle grant
    always_ff @(posedge clk_sys) begin
        if (grant_dl) begin
            mem_cmd <= dl_req ? dl_cmd : dl_cmd_q;
        end else if (grant_hs) begin
            mem_cmd <= hs_req ? hs_cmd : hs_cmd_q;
        end
    end

    ////////////////////////////////////////////////////////////
    // Ready routing
    ////////////////////////////////////////////////////////////

    // Only the owner sees the ready pulse
    always_comb begin
        dl_rdy = mem_rdy && (owner == OWN_DL);
        hs_rdy = mem_rdy && (owner == OWN_HS);
    end

endmodule

/* m92_mem_port_top.sv */
// Channel 3 memory port of the M92 core; memory must answer each mem_req with exactly one mem_rdy
`timescale 1ns/100ps

module m92_mem_port_top (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  m92_mem_pkg::dl_stream_t              dl,
    input  m92_mem_pkg::hs_cmd_t                 hs,
    output logic                                 mem_req,
    output m92_mem_pkg::mem_cmd_t                mem_cmd,
    input  logic                                 mem_rdy,
    input  logic [m92_mem_pkg::MEM_DATA_W-1:0]   mem_dout,
    output logic                                 dl_wait,
    output logic [m92_mem_pkg::DIP_USED*8-1:0]   dip_sw,
    output logic [7:0]                           hs_data_out,
    output logic                                 hs_data_ready
);
    import m92_mem_pkg::*;

    logic     dl_req;
    logic     dl_rdy;
    mem_cmd_t dl_cmd;
    logic     hs_req;
    logic     hs_rdy;
    mem_cmd_t hs_cmd;

    // ROM download and DIP switches
    rom_download_writer i_rom_download_writer (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .dl      (dl),
        .req     (dl_req),
        .cmd     (dl_cmd),
        .rdy     (dl_rdy),
        .dl_wait (dl_wait),
        .dip_sw  (dip_sw)
    );

    // High-score access to CPU RAM
    hiscore_ram_bridge i_hiscore_ram_bridge (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .hs            (hs),
        .req           (hs_req),
        .cmd           (hs_cmd),
        .rdy           (hs_rdy),
        .dout          (mem_dout),
        .hs_data_out   (hs_data_out),
        .hs_data_ready (hs_data_ready)
    );

    ch3_arbiter i_ch3_arbiter (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .dl_req  (dl_req),
        .dl_cmd  (dl_cmd),
        .dl_rdy  (dl_rdy),
        .hs_req  (hs_req),
        .hs_cmd  (hs_cmd),
        .hs_rdy  (hs_rdy),
        .mem_req (mem_req),
        .mem_cmd (mem_cmd),
        .mem_rdy (mem_rdy)
    );

endmodule

/* tb_sdram_model.sv */
// Behavioral word memory for channel 3; one request at a time, ready 3 cycles after mem_req
`timescale 1ns/100ps

module tb_sdram_model (
    input  logic                                 clk_sys,
    input  logic                                 rst_n,
    input  logic                                 mem_req,
    input  m92_mem_pkg::mem_cmd_t                mem_cmd,
    output logic                                 mem_rdy,
    output logic [m92_mem_pkg::MEM_DATA_W-1:0]   mem_dout
);
    import m92_mem_pkg::*;

    localparam int LATENCY = 3;

    // Sparse store keyed by word address
    logic [MEM_DATA_W-1:0] words [logic [MEM_ADDR_W-2:0]];
    mem_cmd_t              cmd_q;
    logic                  busy;
    int                    wait_cnt;
    logic [MEM_ADDR_W-2:0] word_addr;
    logic [MEM_DATA_W-1:0] old_word;

    // Unwritten words return a pattern built from the whole word address
    function automatic logic [MEM_DATA_W-1:0] read_word(input logic [MEM_ADDR_W-2:0] wa);
        if (words.exists(wa)) begin
            return words[wa];
        end
        return wa[15:0] ^ {wa[7:0], wa[23:16]} ^ 16'h5A3C;
    endfunction

    function automatic void write_word(input logic [MEM_ADDR_W-2:0] wa,
                                       input logic [MEM_DATA_W-1:0] data);
        words[wa] = data;
    endfunction

    function automatic int entry_count();
        return words.num();
    endfunction

    assign word_addr = cmd_q.addr[MEM_ADDR_W-1:1];

    always @(posedge clk_sys) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mem_rdy  <= 1'b0;
            mem_dout <= '0;
        end else begin
            mem_rdy <= 1'b0;
            if (mem_req) begin
                cmd_q    <= mem_cmd;
                busy     <= 1'b1;
                wait_cnt <= LATENCY - 1;
            end else if (busy && wait_cnt > 0) begin
                wait_cnt <= wait_cnt - 1;
            end else if (busy) begin
                busy     <= 1'b0;
                mem_rdy  <= 1'b1;
                old_word  = read_word(word_addr);
                mem_dout <= old_word;
                // Byte lanes follow be
                if (!cmd_q.rnw) begin
                    write_word(word_addr, {cmd_q.be[1] ? cmd_q.din[15:8] : old_word[15:8],
                                           cmd_q.be[0] ? cmd_q.din[7:0] : old_word[7:0]});
                end
            end
        end
    end

endmodule

/* tb_m92_mem_port_asserts.sv */
// Channel 3 protocol checks bound to the arbiter; the memory must answer within 16 cycles
`timescale 1ns/100ps

module tb_m92_mem_port_asserts (
    input logic clk_sys,
    input logic rst_n,
    input logic mem_req,
    input logic mem_rdy,
    input logic dl_rdy,
    input logic hs_rdy
);
    logic in_flight;
    int   failures = 0;

    // Set by mem_req, cleared by the matching mem_rdy
    always @(posedge clk_sys) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (mem_req) begin
            in_flight <= 1'b1;
        end else if (mem_rdy) begin
            in_flight <= 1'b0;
        end
    end

    single_in_flight: assert property (@(posedge clk_sys) disable iff (!rst_n)
        mem_req |-> !in_flight)
        else begin
            failures++;
            $error("mem_req issued while a transaction is in flight");
        end

    ready_in_time: assert property (@(posedge clk_sys) disable iff (!rst_n)
        mem_req |-> ##[1:16] mem_rdy)
        else begin
            failures++;
            $error("mem_req not answered by mem_rdy within 16 cycles");
        end

    // Each mem_rdy reaches exactly one requester, never both
    one_owner_ready: assert property (@(posedge clk_sys) disable iff (!rst_n)
        $onehot0({dl_rdy, hs_rdy}) && (mem_rdy == (dl_rdy || hs_rdy)))
        else begin
            failures++;
            $error("mem_rdy not routed to exactly one requester");
        end

endmodule

bind ch3_arbiter tb_m92_mem_port_asserts i_tb_m92_mem_port_asserts (
    .clk_sys (clk_sys),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .dl_rdy  (dl_rdy),
    .hs_rdy  (hs_rdy)
);

/* tb_m92_mem_port.sv */
// Directed tests of the channel 3 port; inputs change 2 ns after the rising edge, memory latency 3
`timescale 1ns/100ps

module tb_m92_mem_port;
    import m92_mem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_TESTS  = 5;
    localparam int WAIT_MAX   = 100;

    logic                  clk_sys = 1'b0;
    logic                  rst_n;
    dl_stream_t            dl;
    hs_cmd_t               hs;
    logic                  mem_req;
    mem_cmd_t              mem_cmd;
    logic                  mem_rdy;
    logic [MEM_DATA_W-1:0] mem_dout;
    logic                  dl_wait;
    logic [DIP_USED*8-1:0] dip_sw;
    logic [7:0]            hs_data_out;
    logic                  hs_data_ready;

    int                    errors;
    int                    tests_failed;
    mem_cmd_t              req_log [$];
    logic [7:0]            rom_bytes [16];
    logic [HS_ADDR_W-1:0]  hs_saved_addr;
    logic [7:0]            hs_saved_data;

    m92_mem_port_top i_m92_mem_port_top (.*);
    tb_sdram_model i_sdram_model (.*);

    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // Every command issued to the memory, in order
    always @(posedge clk_sys) begin
        if (rst_n && mem_req) begin
            req_log.push_back(mem_cmd);
        end
    end

    initial begin
        #((2000 + 200 * NUM_TESTS) * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error: %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        errors++;
    endtask

    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $urandom();
        return r[7:0];
    endfunction

    // Word addresses of the two regions
    function automatic logic [MEM_ADDR_W-2:0] rom_word(input logic [MEM_ADDR_W-1:0] a);
        logic [MEM_ADDR_W-1:0] ba;
        ba = REGION_ROM_BASE + a;
        return ba[MEM_ADDR_W-1:1];
    endfunction

    function automatic logic [MEM_ADDR_W-2:0] cpu_word(input logic [HS_ADDR_W-1:0] a);
        return {REGION_CPU_RAM_BASE[MEM_ADDR_W-1:16], a[15:1]};
    endfunction

    task automatic wait_dl_idle();
        int n;
        n = 0;
        while (dl_wait && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (dl_wait) begin
            report_failure("dl_wait stayed high, download write never completed");
        end
    endtask

    // Host side obeys the back-pressure rule before each strobe
    task automatic send_byte(input logic [7:0] idx, input logic [MEM_ADDR_W-1:0] addr,
                             input logic [7:0] data);
        wait_dl_idle();
        dl.index = idx;
        dl.addr  = addr;
        dl.data  = data;
        dl.wr    = 1'b1;
        next_cycle();
        dl.wr = 1'b0;
    endtask

    task automatic hs_access(input logic write, input logic [HS_ADDR_W-1:0] addr,
                             input logic [7:0] data, output logic [7:0] rdata);
        int n;
        n = 0;
        hs.address  = addr;
        hs.data_in  = data;
        hs.write_en = write;
        hs.read_en  = !write;
        next_cycle();
        while (!hs_data_ready && n < WAIT_MAX) begin
            next_cycle();
            n++;
        end
        if (!hs_data_ready) begin
            report_failure("hs_data_ready never pulsed for a high-score access");
        end
        rdata       = hs_data_out;
        hs.write_en = 1'b0;
        hs.read_en  = 1'b0;
        next_cycle();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic test_rom_packing();
        int e0;
        int first;
        e0    = errors;
        first = req_log.size();
        dl.download = 1'b1;
        for (int i = 0; i < 16; i++) begin
            rom_bytes[i] = rand_byte();
            send_byte(IDX_ROM, MEM_ADDR_W'(i), rom_bytes[i]);
        end
        wait_dl_idle();
        dl.download = 1'b0;
        next_cycle();
        if (req_log.size() - first != 8) begin
            report_mismatch("request count", req_log.size() - first, 8);
        end
        for (int w = 0; w < 8; w++) begin
            if (i_sdram_model.read_word(rom_word(MEM_ADDR_W'(2 * w))) !==
                {rom_bytes[2*w+1], rom_bytes[2*w]}) begin
                report_mismatch("rom word", i_sdram_model.read_word(rom_word(MEM_ADDR_W'(2 * w))),
                                {rom_bytes[2*w+1], rom_bytes[2*w]});
            end
        end
        finish_test("rom download packing", e0);
    endtask

    task automatic test_flush();
        int                    e0;
        logic [7:0]            b [5];
        logic [MEM_DATA_W-1:0] old;
        mem_cmd_t              last;
        e0  = errors;
        old = {rand_byte(), rand_byte()};
        i_sdram_model.write_word(rom_word(25'h24), old);
        dl.download = 1'b1;
        for (int i = 0; i < 5; i++) begin
            b[i] = rand_byte();
            send_byte(IDX_ROM, MEM_ADDR_W'(32 + i), b[i]);
        end
        wait_dl_idle();
        dl.download = 1'b0;
        next_cycle();
        wait_dl_idle();
        last = req_log[$];
        if (last.be !== 2'b01) begin
            report_mismatch("mem_cmd.be", last.be, 2'b01);
        end
        if (last.addr !== REGION_ROM_BASE + 25'h24) begin
            report_mismatch("mem_cmd.addr", last.addr, REGION_ROM_BASE + 25'h24);
        end
        if (i_sdram_model.read_word(rom_word(25'h24)) !== {old[15:8], b[4]}) begin
            report_mismatch("flush word", i_sdram_model.read_word(rom_word(25'h24)),
                            {old[15:8], b[4]});
        end
        finish_test("trailing byte flush", e0);
    endtask

    task automatic test_dip_capture();
        int         e0;
        logic [7:0] d [3];
        e0 = errors;
        if (dip_sw !== 24'hFFFFFF) begin
            report_mismatch("dip_sw", dip_sw, 24'hFFFFFF);
        end
        dl.download = 1'b1;
        for (int i = 0; i < 3; i++) begin
            d[i] = rand_byte();
            send_byte(IDX_DIP, MEM_ADDR_W'(i), d[i]);
        end
        // Beyond the bank, must not alias onto byte 1
        send_byte(IDX_DIP, 25'd9, rand_byte());
        dl.download = 1'b0;
        next_cycle();
        if (dip_sw !== {d[2], d[1], d[0]}) begin
            report_mismatch("dip_sw", dip_sw, {d[2], d[1], d[0]});
        end
        finish_test("dip capture", e0);
    endtask

    task automatic test_hiscore();
        int                    e0;
        int                    count0;
        logic [31:0]           r;
        logic [HS_ADDR_W-1:0]  a [2];
        logic [7:0]            v [2];
        logic [7:0]            rd;
        logic [MEM_DATA_W-1:0] old;
        logic [MEM_DATA_W-1:0] exp;
        logic [MEM_DATA_W-1:0] snap [8];
        e0     = errors;
        count0 = i_sdram_model.entry_count();
        for (int w = 0; w < 8; w++) begin
            snap[w] = i_sdram_model.read_word(rom_word(MEM_ADDR_W'(2 * w)));
        end
        // Even word in the lower half, odd in the upper, bits 19..16 random
        r    = $urandom();
        a[0] = {r[19:16], 1'b0, r[14:1], 1'b0};
        r    = $urandom();
        a[1] = {r[19:16], 1'b1, r[14:1], 1'b1};
        for (int k = 0; k < 2; k++) begin
            v[k] = rand_byte();
            old  = i_sdram_model.read_word(cpu_word(a[k]));
            exp  = a[k][0] ? {v[k], old[7:0]} : {old[15:8], v[k]};
            hs_access(1'b1, a[k], v[k], rd);
            if (i_sdram_model.read_word(cpu_word(a[k])) !== exp) begin
                report_mismatch("cpu ram word", i_sdram_model.read_word(cpu_word(a[k])), exp);
            end
        end
        for (int k = 0; k < 2; k++) begin
            hs_access(1'b0, a[k], 8'h00, rd);
            if (rd !== v[k]) begin
                report_mismatch("hs_data_out", rd, v[k]);
            end
        end
        for (int w = 0; w < 8; w++) begin
            if (i_sdram_model.read_word(rom_word(MEM_ADDR_W'(2 * w))) !== snap[w]) begin
                report_failure("a rom word changed during high-score access");
            end
        end
        if (i_sdram_model.entry_count() != count0 + 2) begin
            report_mismatch("model entries", i_sdram_model.entry_count(), count0 + 2);
        end
        hs_saved_addr = a[1];
        hs_saved_data = v[1];
        finish_test("high-score write and read", e0);
    endtask

    task automatic test_priority();
        int         e0;
        int         first;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [7:0] rd;
        e0    = errors;
        first = req_log.size();
        lo    = rand_byte();
        hi    = rand_byte();
        dl.download = 1'b1;
        send_byte(IDX_ROM, 25'h40, lo);
        send_byte(IDX_ROM, 25'h41, hi);
        if (!dl_wait) begin
            report_failure("download write was not in flight when read_en rose");
        end
        hs_access(1'b0, hs_saved_addr, 8'h00, rd);
        if (rd !== hs_saved_data) begin
            report_mismatch("hs_data_out", rd, hs_saved_data);
        end
        wait_dl_idle();
        dl.download = 1'b0;
        next_cycle();
        if (req_log.size() - first != 2) begin
            report_mismatch("request count", req_log.size() - first, 2);
        end else if (req_log[first].rnw !== 1'b0 || req_log[first+1].rnw !== 1'b1) begin
            report_failure("high-score read was not deferred behind the download write");
        end
        if (i_sdram_model.read_word(rom_word(25'h40)) !== {hi, lo}) begin
            report_mismatch("rom word", i_sdram_model.read_word(rom_word(25'h40)), {hi, lo});
        end
        finish_test("priority and deferral", e0);
    endtask

    initial begin
        int seed_init;
        errors       = 0;
        tests_failed = 0;
        seed_init    = $urandom(84118);
        rst_n        = 1'b0;
        dl           = '0;
        hs           = '0;
        repeat (2) @(posedge clk_sys);
        #2;
        rst_n = 1'b1;
        next_cycle();
        test_rom_packing();
        test_flush();
        test_dip_capture();
        test_hiscore();
        test_priority();
        errors += i_m92_mem_port_top.i_ch3_arbiter.i_tb_m92_mem_port_asserts.failures;
        $display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* project.f */
m92_mem_pkg.sv
rom_download_writer.sv
hiscore_ram_bridge.sv
ch3_arbiter.sv
m92_mem_port_top.sv
tb_sdram_model.sv
tb_m92_mem_port_asserts.sv
tb_m92_mem_port.sv
